/* all.f */
logic/ntm_fixed_pkg.sv
logic/ntm_mem_pkg.sv
logic/scratch_memory.sv
logic/mem_arbiter.sv
logic/logistic_pla.sv
logic/matrix_logistic_engine.sv
logic/logistic_top.sv
tests/logistic_assertions.sv
tests/tb_logistic.sv

/* logic/logistic_pla.sv */
//////////////////////////////////////////////////
// Piecewise-linear logistic evaluator
// Two register stages, one result per cycle,
// no stall
//////////////////////////////////////////////////

`timescale 1ns/1ps

module logistic_pla (
  input  logic                  CLK,
  input  logic                  RST,
  input  ntm_fixed_pkg::fixed_t x,
  input  logic                  in_valid,
  output ntm_fixed_pkg::fixed_t y,
  output logic                  out_valid
);

  import ntm_fixed_pkg::*;

  // One extra bit so that |-8.0| fits
  localparam int MAG_W = DATA_W + 1;

  logic signed [MAG_W-1:0] x_ext;
  logic [MAG_W-1:0]        mag;
  logic [1:0]              seg;

  // Stage 1 registers
  logic             s1_valid;
  logic             s1_neg;
  logic [MAG_W-1:0] s1_mag;
  logic [1:0]       s1_seg;

  logic [MAG_W-1:0] y_pos;
  fixed_t           y_next;

  //////////////////////////////////////////////////
  // Stage 1: magnitude and segment
  //////////////////////////////////////////////////

  assign x_ext = x;
  assign mag   = x_ext[MAG_W-1] ? MAG_W'(-x_ext) : MAG_W'(x_ext);

  // 0: below 1.0, 1: up to 2.375, 2: up to 5.0, 3: saturated
  always_comb begin
    if (mag >= MAG_W'(BREAK_SAT)) begin
      seg = 2'd3;
    end else if (mag >= MAG_W'(BREAK_MID)) begin
      seg = 2'd2;
    end else if (mag >= MAG_W'(BREAK_LO)) begin
      seg = 2'd1;
    end else begin
      seg = 2'd0;
    end
  end

  always_ff @(posedge CLK) begin
    s1_neg <= x_ext[MAG_W-1];
    s1_mag <= mag;
    s1_seg <= seg;
  end

  //////////////////////////////////////////////////
  // Stage 2: slope, offset and reflection
  //////////////////////////////////////////////////

  always_comb begin
    case (s1_seg)
      2'd0:    y_pos = (s1_mag >> SHIFT_LO) + MAG_W'(OFFSET_LO);
      2'd1:    y_pos = (s1_mag >> SHIFT_MID) + MAG_W'(OFFSET_MID);
      2'd2:    y_pos = (s1_mag >> SHIFT_HI) + MAG_W'(OFFSET_HI);
      default: y_pos = MAG_W'(ONE_FIX);
    endcase
    // Negative input gives 1 - y
    y_next = s1_neg ? fixed_t'(MAG_W'(ONE_FIX) - y_pos) : fixed_t'(y_pos);
  end

  always_ff @(posedge CLK) begin
    y <= y_next;
  end

  // Valid pipe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

endmodule

/* logic/logistic_top.sv */
//////////////////////////////////////////////////
// Matrix logistic subsystem
// Host port and engine share one scratchpad
// through the credit-based arbiter
//////////////////////////////////////////////////

`timescale 1ns/1ps

module logistic_top #(
  parameter int ADDR_W  = 8,
  parameter int CREDITS = 4
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  ntm_mem_pkg::mat_cmd_t cmd,
  input  ntm_mem_pkg::mem_req_t host_req,
  input  logic                  host_req_valid,
  output logic                  busy,
  output logic                  done,
  output logic                  host_credit,
  output ntm_mem_pkg::mem_rsp_t host_rsp,
  output logic                  host_rsp_valid
);

  import ntm_mem_pkg::*;

  // Engine side of the arbiter
  mem_req_t eng_req;
  logic     eng_req_valid;
  logic     eng_credit;
  mem_rsp_t eng_rsp;
  logic     eng_rsp_valid;

  // Scratchpad side
  mem_req_t mem_req;
  logic     mem_req_valid;
  mem_rsp_t mem_rsp;
  logic     mem_rsp_valid;

  matrix_logistic_engine #(
    .ADDR_W (ADDR_W),
    .CREDITS(CREDITS)
  ) u_engine (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .cmd          (cmd),
    .mem_credit   (eng_credit),
    .mem_rsp      (eng_rsp),
    .mem_rsp_valid(eng_rsp_valid),
    .busy         (busy),
    .done         (done),
    .mem_req      (eng_req),
    .mem_req_valid(eng_req_valid)
  );

  mem_arbiter #(
    .CREDITS(CREDITS)
  ) u_arbiter (
    .CLK           (CLK),
    .RST           (RST),
    .host_req      (host_req),
    .host_req_valid(host_req_valid),
    .eng_req       (eng_req),
    .eng_req_valid (eng_req_valid),
    .mem_rsp       (mem_rsp),
    .mem_rsp_valid (mem_rsp_valid),
    .host_credit   (host_credit),
    .eng_credit    (eng_credit),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .host_rsp      (host_rsp),
    .host_rsp_valid(host_rsp_valid),
    .eng_rsp       (eng_rsp),
    .eng_rsp_valid (eng_rsp_valid)
  );

  scratch_memory #(
    .ADDR_W(ADDR_W)
  ) u_memory (
    .CLK      (CLK),
    .RST      (RST),
    .req      (mem_req),
    .req_valid(mem_req_valid),
    .rsp      (mem_rsp),
    .rsp_valid(mem_rsp_valid)
  );

endmodule

/* logic/matrix_logistic_engine.sv */
//////////////////////////////////////////////////
// Matrix logistic engine
// Walks a matrix by row and column, streams each
// element through the evaluator, writes back
//////////////////////////////////////////////////

`timescale 1ns/1ps

module matrix_logistic_engine #(
  parameter int ADDR_W  = 8,
  parameter int CREDITS = 4
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  ntm_mem_pkg::mat_cmd_t cmd,
  input  logic                  mem_credit,
  input  ntm_mem_pkg::mem_rsp_t mem_rsp,
  input  logic                  mem_rsp_valid,
  output logic                  busy,
  output logic                  done,
  output ntm_mem_pkg::mem_req_t mem_req,
  output logic                  mem_req_valid
);

  import ntm_fixed_pkg::*;
  import ntm_mem_pkg::*;

  localparam int CNT_W  = 2 * RC_W;
  localparam int CRED_W = $clog2(CREDITS + 1);

  engine_state_e state;
  mat_cmd_t      cmd_q;

  // Read walk, j inner and i outer
  logic [RC_W-1:0]  idx_i;
  logic [RC_W-1:0]  idx_j;
  logic [CNT_W-1:0] row_off;

  logic [CNT_W-1:0]  total;
  logic [CNT_W-1:0]  rd_cnt;
  logic [CNT_W-1:0]  wr_cnt;
  logic [CNT_W-1:0]  in_flight;
  logic [CRED_W-1:0] cred;
  logic [CRED_W-1:0] cred_next;

  logic              rd_issue;
  logic              wr_issue;
  logic              last_rd;
  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W-1:0] wr_addr;

  fixed_t res_y;
  logic   res_valid;

  //////////////////////////////////////////////////
  // Request issue
  //////////////////////////////////////////////////

  // Reads that still owe a write
  assign in_flight = rd_cnt - wr_cnt;
  assign last_rd   = (idx_i == cmd_q.rows - 1'b1) && (idx_j == cmd_q.cols - 1'b1);

  // Results first; a read keeps one credit back per element
  assign wr_issue = res_valid;
  assign rd_issue = (state == ENG_RUN) && !res_valid && (cred > in_flight);

  assign rd_addr = ADDR_W'(cmd_q.src_base) + ADDR_W'(row_off) + ADDR_W'(idx_j);
  assign wr_addr = ADDR_W'(cmd_q.dst_base) + ADDR_W'(wr_cnt);

  always_comb begin
    mem_req_valid = wr_issue || rd_issue;
    mem_req.op    = wr_issue ? MEM_WRITE : MEM_READ;
    mem_req.addr  = MEM_AW'(wr_issue ? wr_addr : rd_addr);
    mem_req.wdata = res_y;
  end

  assign cred_next = cred - CRED_W'(mem_req_valid) + CRED_W'(mem_credit);
  assign busy      = (state != ENG_IDLE);

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= ENG_IDLE;
      done    <= 1'b0;
      cred    <= CRED_W'(CREDITS);
      idx_i   <= '0;
      idx_j   <= '0;
      row_off <= '0;
      rd_cnt  <= '0;
      wr_cnt  <= '0;
    end else begin
      done <= 1'b0;
      cred <= cred_next;
      if (wr_issue) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      case (state)
        ENG_IDLE: begin
          if (start) begin
            idx_i   <= '0;
            idx_j   <= '0;
            row_off <= '0;
            rd_cnt  <= '0;
            wr_cnt  <= '0;
            // Empty matrix finishes at once
            if (cmd.rows == '0 || cmd.cols == '0) begin
              done <= 1'b1;
            end else begin
              state <= ENG_RUN;
            end
          end
        end
        ENG_RUN: begin
          if (rd_issue) begin
            rd_cnt <= rd_cnt + 1'b1;
            if (last_rd) begin
              state <= ENG_DRAIN;
            end else if (idx_j == cmd_q.cols - 1'b1) begin
              idx_j   <= '0;
              idx_i   <= idx_i + 1'b1;
              row_off <= row_off + CNT_W'(cmd_q.cols);
            end else begin
              idx_j <= idx_j + 1'b1;
            end
          end
        end
        ENG_DRAIN: begin
          // Last write granted once every credit is home
          if (wr_cnt == total && mem_credit && cred_next == CRED_W'(CREDITS)) begin
            done  <= 1'b1;
            state <= ENG_IDLE;
          end
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

  // Command capture
  always_ff @(posedge CLK) begin
    if (state == ENG_IDLE && start) begin
      cmd_q <= cmd;
      total <= cmd.rows * cmd.cols;
    end
  end

  // Evaluator, fed straight from read data
  logistic_pla u_pla (
    .CLK      (CLK),
    .RST      (RST),
    .x        (mem_rsp.rdata),
    .in_valid (mem_rsp_valid),
    .y        (res_y),
    .out_valid(res_valid)
  );

endmodule

/* logic/mem_arbiter.sv */
//////////////////////////////////////////////////
// Scratchpad arbiter
// Credit-managed request FIFO per port, round
// robin grant, read responses routed by owner
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_arbiter #(
  parameter int CREDITS = 4
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  ntm_mem_pkg::mem_req_t host_req,
  input  logic                  host_req_valid,
  input  ntm_mem_pkg::mem_req_t eng_req,
  input  logic                  eng_req_valid,
  input  ntm_mem_pkg::mem_rsp_t mem_rsp,
  input  logic                  mem_rsp_valid,
  output logic                  host_credit,
  output logic                  eng_credit,
  output ntm_mem_pkg::mem_req_t mem_req,
  output logic                  mem_req_valid,
  output ntm_mem_pkg::mem_rsp_t host_rsp,
  output logic                  host_rsp_valid,
  output ntm_mem_pkg::mem_rsp_t eng_rsp,
  output logic                  eng_rsp_valid
);

  import ntm_mem_pkg::*;

  localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
  localparam int CNT_W = $clog2(CREDITS + 1);

  // Port 0 is the host, port 1 the engine
  mem_req_t   in_req [2];
  logic [1:0] in_valid;
  mem_req_t   head [2];
  logic [1:0] nonempty;
  logic [1:0] grant;

  // Last port that won, and owner of the read in flight
  logic last_port;
  logic owner_q;

  // Circular pointer step
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(CREDITS - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_req[0]   = host_req;
  assign in_req[1]   = eng_req;
  assign in_valid[0] = host_req_valid;
  assign in_valid[1] = eng_req_valid;

  //////////////////////////////////////////////////
  // Request FIFOs
  //////////////////////////////////////////////////

  for (genvar p = 0; p < 2; p++) begin : g_port
    mem_req_t         buf_q [CREDITS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Credits guarantee room, so no full check
    always_ff @(posedge CLK or posedge RST) begin
      if (RST) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (in_valid[p]) begin
          wr_ptr <= ptr_inc(wr_ptr);
        end
        if (grant[p]) begin
          rd_ptr <= ptr_inc(rd_ptr);
        end
        count <= count + CNT_W'(in_valid[p]) - CNT_W'(grant[p]);
      end
    end

    always_ff @(posedge CLK) begin
      if (in_valid[p]) begin
        buf_q[wr_ptr] <= in_req[p];
      end
    end

    assign head[p]     = buf_q[rd_ptr];
    assign nonempty[p] = (count != '0);
  end

  //////////////////////////////////////////////////
  // Round-robin grant
  //////////////////////////////////////////////////

  // Both waiting, so the port that did not win last goes
  always_comb begin
    if (nonempty == 2'b11) begin
      grant = last_port ? 2'b01 : 2'b10;
    end else begin
      grant = nonempty;
    end
  end

  assign mem_req       = grant[1] ? head[1] : head[0];
  assign mem_req_valid = |grant;

  // A grant frees one buffer entry
  assign host_credit = grant[0];
  assign eng_credit  = grant[1];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      last_port <= 1'b0;
      owner_q   <= 1'b0;
    end else if (mem_req_valid) begin
      last_port <= grant[1];
      // Response comes back the next cycle
      owner_q   <= grant[1];
    end
  end

  //////////////////////////////////////////////////
  // Response routing
  //////////////////////////////////////////////////

  assign host_rsp       = mem_rsp;
  assign eng_rsp        = mem_rsp;
  assign host_rsp_valid = mem_rsp_valid && !owner_q;
  assign eng_rsp_valid  = mem_rsp_valid && owner_q;

endmodule

/* logic/ntm_fixed_pkg.sv */
//////////////////////////////////////////////////
// Fixed-point definitions for the logistic path
// Signed Q4.12 element format plus the segment
// constants of the piecewise-linear logistic
//////////////////////////////////////////////////

package ntm_fixed_pkg;

  //////////////////////////////////////////////////
  // Number format
  //////////////////////////////////////////////////

  // One matrix element per 16-bit word
  localparam int DATA_W    = 16;
  localparam int FRAC_BITS = 12;

  typedef logic signed [DATA_W-1:0] fixed_t;

  // 1.0 in Q4.12
  localparam fixed_t ONE_FIX = fixed_t'(1 << FRAC_BITS);

  //////////////////////////////////////////////////
  // Segment constants
  //////////////////////////////////////////////////

  // Break points 1.0, 2.375 and 5.0
  localparam fixed_t BREAK_LO  = ONE_FIX;
  localparam fixed_t BREAK_MID = fixed_t'(19 << (FRAC_BITS - 3));
  localparam fixed_t BREAK_SAT = fixed_t'(5 << FRAC_BITS);

  // Slopes 1/4, 1/8, 1/32 as right shifts
  localparam int SHIFT_LO  = 2;
  localparam int SHIFT_MID = 3;
  localparam int SHIFT_HI  = 5;

  // Offsets 0.5, 0.625 and 0.84375
  localparam fixed_t OFFSET_LO  = fixed_t'(1 << (FRAC_BITS - 1));
  localparam fixed_t OFFSET_MID = fixed_t'(5 << (FRAC_BITS - 3));
  localparam fixed_t OFFSET_HI  = fixed_t'(27 << (FRAC_BITS - 5));

endpackage

/* logic/ntm_mem_pkg.sv */
//////////////////////////////////////////////////
// Scratchpad access and command definitions
// Request and response words of the shared
// memory, matrix command and engine states
//////////////////////////////////////////////////

package ntm_mem_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Widest address a request can carry
  localparam int MEM_AW = 13;

  // Row and column count width
  localparam int RC_W = 6;

  //////////////////////////////////////////////////
  // Memory access
  //////////////////////////////////////////////////

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // One scratchpad request, 30 bits
  typedef struct packed {
    mem_op_e                op;
    logic [MEM_AW-1:0]      addr;
    ntm_fixed_pkg::fixed_t  wdata;
  } mem_req_t;

  // Read data back to the requester
  typedef struct packed {
    ntm_fixed_pkg::fixed_t  rdata;
  } mem_rsp_t;

  //////////////////////////////////////////////////
  // Matrix command and engine control
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [MEM_AW-1:0] src_base;
    logic [MEM_AW-1:0] dst_base;
    logic [RC_W-1:0]   rows;
    logic [RC_W-1:0]   cols;
  } mat_cmd_t;

  // Idle, issuing reads, waiting for last writes
  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_RUN,
    ENG_DRAIN
  } engine_state_e;

endpackage

/* logic/scratch_memory.sv */
//////////////////////////////////////////////////
// Scratchpad memory
// Single port, synchronous, read data one
// cycle after the request
//////////////////////////////////////////////////

`timescale 1ns/1ps

module scratch_memory #(
  parameter int ADDR_W = 8
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  ntm_mem_pkg::mem_req_t req,
  input  logic                  req_valid,
  output ntm_mem_pkg::mem_rsp_t rsp,
  output logic                  rsp_valid
);

  import ntm_fixed_pkg::*;
  import ntm_mem_pkg::*;

  // Storage array, no reset
  fixed_t mem_q [2**ADDR_W];

  logic [ADDR_W-1:0] addr;
  logic              is_read;

  // Only the low bits address this array
  assign addr    = req.addr[ADDR_W-1:0];
  assign is_read = req_valid && (req.op == MEM_READ);

  // Write port and registered read data
  always_ff @(posedge CLK) begin
    if (req_valid && req.op == MEM_WRITE) begin
      mem_q[addr] <= req.wdata;
    end
    if (is_read) begin
      rsp.rdata <= mem_q[addr];
    end
  end

  // Valid flag follows a read by one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= is_read;
    end
  end

endmodule

/* tests/logistic_assertions.sv */
//////////////////////////////////////////////////
// Arbiter protocol checks
// Credit use, single grant and read response
// timing on the scratchpad side
//////////////////////////////////////////////////

`timescale 1ns/1ps

module logistic_assertions #(
  parameter int CREDITS = 4
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  host_req_valid,
  input  logic                  eng_req_valid,
  input  logic                  host_credit,
  input  logic                  eng_credit,
  input  ntm_mem_pkg::mem_req_t mem_req,
  input  logic                  mem_req_valid,
  input  logic                  mem_rsp_valid
);

  import ntm_mem_pkg::*;

  localparam int CNT_W = $clog2(CREDITS + 1);

  // Credits each requester still holds
  logic [CNT_W-1:0] host_left;
  logic [CNT_W-1:0] eng_left;
  logic             read_grant;

  // Assertion failures so far
  int fail_cnt = 0;

  assign read_grant = mem_req_valid && (mem_req.op == MEM_READ);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      host_left <= CNT_W'(CREDITS);
      eng_left  <= CNT_W'(CREDITS);
    end else begin
      host_left <= host_left - CNT_W'(host_req_valid) + CNT_W'(host_credit);
      eng_left  <= eng_left - CNT_W'(eng_req_valid) + CNT_W'(eng_credit);
    end
  end

  // No request without a credit in hand
  host_credit_ok: assert property (@(posedge CLK) disable iff (RST)
    host_req_valid |-> host_left != '0)
    else begin
      fail_cnt++;
      $error("host sent a request with no credit left");
    end

  eng_credit_ok: assert property (@(posedge CLK) disable iff (RST)
    eng_req_valid |-> eng_left != '0)
    else begin
      fail_cnt++;
      $error("engine sent a request with no credit left");
    end

  // One grant per cycle
  single_grant: assert property (@(posedge CLK) disable iff (RST)
    !(host_credit && eng_credit))
    else begin
      fail_cnt++;
      $error("both ports granted in one cycle");
    end

  // Read data exactly one cycle after a read grant
  rsp_after_read: assert property (@(posedge CLK) disable iff (RST)
    read_grant |=> mem_rsp_valid)
    else begin
      fail_cnt++;
      $error("read grant without response one cycle later");
    end

  rsp_has_read: assert property (@(posedge CLK) disable iff (RST)
    mem_rsp_valid |-> $past(read_grant))
    else begin
      fail_cnt++;
      $error("read response without a read grant one cycle before");
    end

endmodule

bind mem_arbiter logistic_assertions #(
  .CREDITS(CREDITS)
) u_assertions (
  .CLK           (CLK),
  .RST           (RST),
  .host_req_valid(host_req_valid),
  .eng_req_valid (eng_req_valid),
  .host_credit   (host_credit),
  .eng_credit    (eng_credit),
  .mem_req       (mem_req),
  .mem_req_valid (mem_req_valid),
  .mem_rsp_valid (mem_rsp_valid)
);

/* tests/tb_logistic.sv */
//////////////////////////////////////////////////
// Matrix logistic subsystem testbench
// Host traffic and engine runs from a fixed seed,
// checked against a shadow memory and rule model
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_logistic;

  import ntm_fixed_pkg::*;
  import ntm_mem_pkg::*;

  localparam int ADDR_W  = 8;
  localparam int CREDITS = 4;
  // Element count over all runs (8x8, 1x9, 8x8, 1x8, 8x1, 3x5, 5x3)
  localparam int LIMIT = (64 + 9 + 64 + 8 + 8 + 15 + 15) * 8 + 2000;

  // Host request plus what its response must be
  typedef struct packed {
    mem_req_t req;
    logic     is_result;
    fixed_t   exp;
  } host_op_t;

  logic     CLK;
  logic     RST;
  logic     start;
  mat_cmd_t cmd;
  mem_req_t host_req;
  logic     host_req_valid;
  logic     busy;
  logic     done;
  logic     host_credit;
  mem_rsp_t host_rsp;
  logic     host_rsp_valid;

  fixed_t   shadow [2**ADDR_W];
  host_op_t op_q [$];
  host_op_t exp_q [$];

  int    host_cred = CREDITS;
  int    errors    = 0;
  int    checks    = 0;
  int    tests     = 0;
  int    cycles    = 0;
  int    done_cnt  = 0;
  int    c0;
  int    e0;
  int    d0;
  bit    busy_s    = 1'b0;
  bit    sent_now  = 1'b0;
  string test_name = "reset";

  logistic_top #(
    .ADDR_W (ADDR_W),
    .CREDITS(CREDITS)
  ) dut (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .cmd           (cmd),
    .host_req      (host_req),
    .host_req_valid(host_req_valid),
    .busy          (busy),
    .done          (done),
    .host_credit   (host_credit),
    .host_rsp      (host_rsp),
    .host_rsp_valid(host_rsp_valid)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Model and compare
  //////////////////////////////////////////////////

  // Piecewise-linear logistic on Q4.12 with truncating shifts
  function automatic fixed_t logistic_ref(input fixed_t x);
    int a;
    int y;
    a = (x < 0) ? -int'(x) : int'(x);
    if (a >= 20480) begin
      y = 4096;
    end else if (a >= 9728) begin
      y = (a >> 5) + 3456;
    end else if (a >= 4096) begin
      y = (a >> 3) + 2560;
    end else begin
      y = (a >> 2) + 2048;
    end
    return (x < 0) ? fixed_t'(4096 - y) : fixed_t'(y);
  endfunction

  task automatic check_word(input string name, input mem_rsp_t exp, input mem_rsp_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp.rdata, act.rdata);
    end
  endtask

  task automatic check_fixed(input string name, input fixed_t exp, input fixed_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Host driver called once per clock
  //////////////////////////////////////////////////

  task automatic tick();
    host_op_t op;
    @(posedge CLK);
    // Values seen here are the ones the DUT took at this edge
    host_cred = host_cred + int'(host_credit) - int'(host_req_valid);
    busy_s    = busy;
    if (done) begin
      done_cnt++;
    end
    if (host_rsp_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("%s: host got a read response it never asked for", test_name);
      end else begin
        op = exp_q.pop_front();
        if (op.is_result) begin
          check_fixed(test_name, op.exp, host_rsp.rdata);
        end else begin
          check_word(test_name, mem_rsp_t'(op.exp), host_rsp);
        end
      end
    end
    // Next request only with a credit in hand
    sent_now = (op_q.size() != 0) && (host_cred > 0);
    if (sent_now) begin
      op = op_q.pop_front();
      if (op.req.op == MEM_READ) begin
        exp_q.push_back(op);
      end
      host_req <= op.req;
    end
    host_req_valid <= sent_now;
  endtask

  task automatic queue_write(input int addr, input fixed_t data);
    host_op_t op;
    shadow[addr] = data;
    op = '{req: '{op: MEM_WRITE, addr: MEM_AW'(addr), wdata: data}, is_result: 1'b0, exp: data};
    op_q.push_back(op);
  endtask

  // Expected value fixed when the read is queued in host order
  task automatic queue_read(input int addr, input bit is_result, input fixed_t exp);
    host_op_t op;
    op = '{req: '{op: MEM_READ, addr: MEM_AW'(addr), wdata: '0}, is_result: is_result, exp: exp};
    op_q.push_back(op);
  endtask

  task automatic drain();
    while (op_q.size() != 0 || exp_q.size() != 0 || sent_now || host_cred != CREDITS) begin
      tick();
    end
  endtask

  task automatic load_random(input int src, input int n);
    for (int k = 0; k < n; k++) begin
      queue_write(src + k, fixed_t'($urandom));
    end
    drain();
  endtask

  //////////////////////////////////////////////////
  // Engine commands
  //////////////////////////////////////////////////

  task automatic start_cmd(input int src, input int dst, input int rows, input int cols);
    if (busy_s) begin
      errors++;
      $display("%s: engine still busy when a new command was due", test_name);
    end
    cmd   <= '{src_base: MEM_AW'(src), dst_base: MEM_AW'(dst),
               rows: RC_W'(rows), cols: RC_W'(cols)};
    start <= 1'b1;
    tick();
    start <= 1'b0;
  endtask

  task automatic wait_done();
    int d;
    d = done_cnt;
    while (done_cnt == d) begin
      tick();
    end
    if (busy_s) begin
      errors++;
      $display("%s: busy stayed high after done", test_name);
    end
  endtask

  // Each destination word against the rule applied to its source
  task automatic read_results(input int src, input int dst, input int n);
    fixed_t exp;
    for (int k = 0; k < n; k++) begin
      exp = logistic_ref(shadow[src + k]);
      shadow[dst + k] = exp;
      queue_read(dst + k, 1'b1, exp);
    end
    drain();
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    c0 = checks;
    e0 = errors;
    d0 = done_cnt;
  endtask

  task automatic end_test(input int dones);
    if (done_cnt - d0 != dones) begin
      errors++;
      $display("%s: saw %0d done pulses where %0d were due", test_name, done_cnt - d0, dones);
    end
    tests++;
    $display("%-20s %0d checks, %0d errors", test_name, checks - c0, errors - e0);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    fixed_t edge_in  [9] = '{16'h0000, 16'h1000, 16'hF000, 16'h2600, 16'hDA00,
                             16'h5000, 16'hB000, 16'h8000, 16'h7FFF};
    fixed_t edge_out [9] = '{16'h0800, 16'h0C00, 16'h0400, 16'h0EB0, 16'h0150,
                             16'h1000, 16'h0000, 16'h0000, 16'h1000};
    int a;
    void'($urandom(32'hf6e8e7be));
    RST            = 1'b1;
    start          = 1'b0;
    cmd            = '0;
    host_req       = '0;
    host_req_valid = 1'b0;
    repeat (16) @(posedge CLK);
    RST <= 1'b0;

    // Writes to host region 192..211, then reads in random order
    begin_test("host_write_read");
    for (int k = 0; k < 20; k++) begin
      queue_write(192 + k, fixed_t'($urandom));
    end
    for (int k = 0; k < 20; k++) begin
      a = 192 + int'($urandom_range(19, 0));
      queue_read(a, 1'b0, shadow[a]);
    end
    drain();
    end_test(0);

    begin_test("matrix_8x8");
    load_random(0, 64);
    start_cmd(0, 64, 8, 8);
    wait_done();
    read_results(0, 64, 64);
    end_test(1);

    // Break points, saturation and both extremes
    begin_test("edge_values_1x9");
    for (int k = 0; k < 9; k++) begin
      queue_write(128 + k, edge_in[k]);
    end
    drain();
    start_cmd(128, 160, 1, 9);
    wait_done();
    for (int k = 0; k < 9; k++) begin
      queue_read(160 + k, 1'b1, edge_out[k]);
    end
    drain();
    end_test(1);

    // Host traffic on its own region while the engine runs
    begin_test("matrix_with_host");
    load_random(0, 64);
    start_cmd(0, 64, 8, 8);
    for (int k = 0; k < 24; k++) begin
      a = 192 + int'($urandom_range(19, 0));
      if ($urandom_range(1, 0) == 1) begin
        queue_write(a, fixed_t'($urandom));
      end else begin
        queue_read(a, 1'b0, shadow[a]);
      end
    end
    wait_done();
    drain();
    read_results(0, 64, 64);
    end_test(1);

    begin_test("shape_1x8");
    load_random(0, 8);
    start_cmd(0, 64, 1, 8);
    wait_done();
    read_results(0, 64, 8);
    end_test(1);

    begin_test("shape_8x1");
    load_random(0, 8);
    start_cmd(0, 64, 8, 1);
    wait_done();
    read_results(0, 64, 8);
    end_test(1);

    // Second command starts right after the first done
    begin_test("back_to_back");
    load_random(0, 15);
    load_random(16, 15);
    start_cmd(0, 64, 3, 5);
    wait_done();
    start_cmd(16, 96, 5, 3);
    wait_done();
    read_results(0, 64, 15);
    read_results(16, 96, 15);
    end_test(2);

    // Failures of the bound arbiter checks
    if (dut.u_arbiter.u_assertions.fail_cnt != 0) begin
      errors += dut.u_arbiter.u_assertions.fail_cnt;
      $display("%0d arbiter protocol assertions failed",
               dut.u_arbiter.u_assertions.fail_cnt);
    end

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Run limit from the total element count
  initial begin
    while (cycles < LIMIT) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles, last test %s", LIMIT, test_name);
    $display("** FAIL **");
    $finish;
  end

endmodule
